// ==== src.f ====
+incdir+common
common/exec_pkg.sv
hdl/operand_capture.sv
alu_rs/alu_rs.sv
branch_rs/branch_rs.sv
hdl/cdb_arbiter.sv
hdl/instr_exec.sv
verification/clk_gen.sv
verification/instr_exec_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile with verilator and run the instr_exec testbench

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps -f src.f --top-module instr_exec_tb
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

out=$(./obj_dir/Vinstr_exec_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "Testbench passed"; then
	exit 0
fi
exit 1

// ==== verification/instr_exec_tb.sv ====
`timescale 1ns/100ps

module instr_exec_tb;

	import exec_pkg::*;

	localparam int TIMEOUT = 50;

	logic                   clk;
	logic                   rst_n;
	logic                   flush;
	rob_index_t       [3:0] rob_raddr;
	logic             [3:0] rob_rdata_valid;
	uint32_t          [3:0] rob_rdata;
	logic             [1:0] alu_taken;
	logic             [1:0] alu_ready;
	rs_index_t        [1:0] alu_index;
	logic             [1:0] branch_taken;
	logic             [1:0] branch_ready;
	rs_index_t        [1:0] branch_index;
	reserve_station_t [1:0] rs;
	cdb_packet_t            cdb;

	// rob contents seen by the read port
	logic    [15:0] rob_valid;
	uint32_t        rob_mem [16];

	cdb_packet_t cdb_log [$];
	integer      seed = 32'hc5c5;
	string       cur_test;
	int          log_start;
	int          errors;
	int          test_errors;
	int          tests_run;
	int          tests_failed;

	clk_gen clk_gen_i (
		.clk_o   ( clk   ),
		.rst_n_o ( rst_n )
	);

	instr_exec instr_exec_i (
		.clk               ( clk             ),
		.rst_n_i           ( rst_n           ),
		.flush_i           ( flush           ),
		.rob_raddr_o       ( rob_raddr       ),
		.rob_rdata_valid_i ( rob_rdata_valid ),
		.rob_rdata_i       ( rob_rdata       ),
		.alu_taken_i       ( alu_taken       ),
		.alu_ready_o       ( alu_ready       ),
		.alu_index_o       ( alu_index       ),
		.branch_taken_i    ( branch_taken    ),
		.branch_ready_o    ( branch_ready    ),
		.branch_index_o    ( branch_index    ),
		.rs_i              ( rs              ),
		.cdb_o             ( cdb             )
	);

	always_comb begin
		for (int p = 0; p < 4; p++) begin
			rob_rdata_valid[p] = rob_valid[rob_raddr[p]];
			rob_rdata[p]       = rob_mem[rob_raddr[p]];
		end
	end

	// every broadcast, sampled mid-cycle
	always @(negedge clk) begin
		if (cdb.valid)
			cdb_log.push_back(cdb);
	end

	function automatic uint32_t alu_model(alu_op_e op, uint32_t a, uint32_t b);
		case (op)
			ADD:     return a + b;
			SUB:     return a - b;
			AND:     return a & b;
			OR:      return a | b;
			XOR:     return a ^ b;
			SLL:     return a << b[4:0];
			SRL:     return a >> b[4:0];
			SLT:     return {31'b0, $signed(a) < $signed(b)};
			default: return '0;
		endcase
	endfunction

	function automatic logic branch_model(branch_cond_e c, uint32_t a, uint32_t b);
		case (c)
			BEQ:     return a == b;
			BNE:     return a != b;
			BLT:     return $signed(a) < $signed(b);
			BGE:     return $signed(a) >= $signed(b);
			default: return 1'b0;
		endcase
	endfunction

	function automatic reserve_station_t alu_entry(alu_op_e op, uint32_t a, uint32_t b,
			logic [1:0] rdy, rob_index_t src0, rob_index_t src1, rob_index_t tag);
		reserve_station_t e;
		e                 = '0;
		e.valid           = 1'b1;
		e.op.alu          = op;
		e.operand[0]      = a;
		e.operand[1]      = b;
		e.operand_ready   = rdy;
		e.operand_addr[0] = src0;
		e.operand_addr[1] = src1;
		e.reorder         = tag;
		return e;
	endfunction

	function automatic reserve_station_t branch_entry(branch_cond_e c, uint32_t a, uint32_t b,
			uint32_t pc, uint32_t imm, logic pred, rob_index_t tag);
		reserve_station_t e;
		e               = '0;
		e.valid         = 1'b1;
		e.unit_branch   = 1'b1;
		e.op.branch     = c;
		e.operand[0]    = a;
		e.operand[1]    = b;
		e.operand_ready = 2'b11;
		e.reorder       = tag;
		e.pc            = pc;
		e.imm           = imm;
		e.pred_taken    = pred;
		return e;
	endfunction

	function automatic int count_tag(rob_index_t tag);
		int n;
		n = 0;
		for (int i = log_start; i < cdb_log.size(); i++) begin
			if (cdb_log[i].reorder == tag)
				n++;
		end
		return n;
	endfunction

	task automatic check_value(string what, uint32_t expected, uint32_t actual);
		if (expected !== actual) begin
			$display("FAILED %s %s: expected %h, actual %h", cur_test, what, expected, actual);
			errors++;
			test_errors++;
		end
	endtask

	task automatic report_error(string msg);
		$display("ERROR in %s: %s", cur_test, msg);
		errors++;
		test_errors++;
	endtask

	task automatic begin_test(string name);
		cur_test    = name;
		test_errors = 0;
		rob_valid   = '0;
		log_start   = cdb_log.size();
	endtask

	task automatic end_test();
		tests_run++;
		if (test_errors != 0)
			tests_failed++;
		$display("test %s finished with %0d errors", cur_test, test_errors);
	endtask

	// offer up to two entries, strobe held for one cycle
	task automatic dispatch(reserve_station_t e0, reserve_station_t e1,
			logic [1:0] alu_t, logic [1:0] br_t);
		int n;
		n = 0;
		@(negedge clk);
		while (((alu_ready & alu_t) != alu_t || (branch_ready & br_t) != br_t) &&
		       n < TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (n >= TIMEOUT)
			report_error("station never became ready for dispatch");
		@(posedge clk);
		rs[0]        <= e0;
		rs[1]        <= e1;
		alu_taken    <= alu_t;
		branch_taken <= br_t;
		@(posedge clk);
		rs           <= '0;
		alu_taken    <= '0;
		branch_taken <= '0;
	endtask

	task automatic wait_tag(rob_index_t tag, output cdb_packet_t pkt);
		int   n;
		logic found;
		n     = 0;
		found = 1'b0;
		pkt   = '0;
		while (!found && n < TIMEOUT) begin
			@(posedge clk);
			n++;
			for (int i = log_start; i < cdb_log.size(); i++) begin
				if (!found && cdb_log[i].reorder == tag) begin
					found = 1'b1;
					pkt   = cdb_log[i];
				end
			end
		end
		if (!found)
			report_error($sformatf("no CDB result for tag %0d within %0d cycles", tag, TIMEOUT));
	endtask

	task automatic run_alu_ops();
		cdb_packet_t pkt;
		uint32_t     a;
		uint32_t     b;
		alu_op_e     op;
		begin_test("alu_ops");
		for (int i = 0; i < 8; i++) begin
			op = alu_op_e'(i);
			a  = $random(seed);
			b  = $random(seed);
			dispatch(alu_entry(op, a, b, 2'b11, '0, '0, rob_index_t'(i)), '0, 2'b01, 2'b00);
			wait_tag(rob_index_t'(i), pkt);
			check_value(op.name(), alu_model(op, a, b), pkt.value);
			check_value({op.name(), " is_branch"}, 32'd0, uint32_t'(pkt.is_branch));
		end
		end_test();
	endtask

	task automatic fill_from_rob();
		cdb_packet_t pkt;
		begin_test("rob_fill");
		for (int j = 4; j < 8; j++) begin
			rob_mem[j]   = $random(seed);
			rob_valid[j] = 1'b1;
		end
		dispatch(alu_entry(ADD, '0, '0, 2'b00, 4'd4, 4'd5, 4'd1),
		         alu_entry(XOR, '0, '0, 2'b00, 4'd6, 4'd7, 4'd2), 2'b11, 2'b00);
		wait_tag(4'd1, pkt);
		check_value("slot 0", alu_model(ADD, rob_mem[4], rob_mem[5]), pkt.value);
		wait_tag(4'd2, pkt);
		check_value("slot 1", alu_model(XOR, rob_mem[6], rob_mem[7]), pkt.value);
		end_test();
	endtask

	task automatic wake_from_cdb();
		cdb_packet_t pkt;
		uint32_t     a;
		uint32_t     b;
		uint32_t     c;
		begin_test("cdb_wakeup");
		a = $random(seed);
		b = $random(seed);
		c = $random(seed);
		// consumer operand 1 waits on the producer tag
		dispatch(alu_entry(SUB, a, b, 2'b11, '0, '0, 4'd3),
		         alu_entry(ADD, c, '0, 2'b01, '0, 4'd3, 4'd9), 2'b11, 2'b00);
		wait_tag(4'd9, pkt);
		check_value("consumer", alu_model(ADD, c, alu_model(SUB, a, b)), pkt.value);
		repeat (4) @(posedge clk);
		check_value("producer count", 32'd1, uint32_t'(count_tag(4'd3)));
		check_value("consumer count", 32'd1, uint32_t'(count_tag(4'd9)));
		end_test();
	endtask

	task automatic resolve_branches();
		cdb_packet_t  pkt;
		branch_cond_e cond;
		uint32_t      a;
		uint32_t      b;
		uint32_t      pc;
		uint32_t      imm;
		logic         pred;
		logic         taken;
		int           n;
		begin_test("branch_resolve");
		n = 0;
		for (int c = 0; c < 4; c++) begin
			for (int eq = 0; eq < 2; eq++) begin
				for (int p = 0; p < 2; p++) begin
					cond  = branch_cond_e'(c);
					pred  = (p != 0);
					a     = $random(seed);
					b     = (eq != 0) ? a : a ^ 32'h8000_0001;
					pc    = $random(seed) & 32'hffff_fffc;
					imm   = $random(seed) & 32'h0000_0ffe;
					taken = branch_model(cond, a, b);
					dispatch(branch_entry(cond, a, b, pc, imm, pred, rob_index_t'(n)), '0,
					         2'b00, 2'b01);
					wait_tag(rob_index_t'(n), pkt);
					check_value({cond.name(), " value"}, taken ? pc + imm : pc + 32'd4,
					            pkt.value);
					check_value({cond.name(), " taken"}, uint32_t'(taken),
					            uint32_t'(pkt.taken));
					check_value({cond.name(), " mispredict"}, uint32_t'(taken != pred),
					            uint32_t'(pkt.mispredict));
					check_value({cond.name(), " is_branch"}, 32'd1, uint32_t'(pkt.is_branch));
					n++;
				end
			end
		end
		end_test();
	endtask

	task automatic fill_and_release();
		cdb_packet_t      pkt;
		alu_op_e          ops [4];
		uint32_t          a [4];
		reserve_station_t e [4];
		uint32_t          pc;
		uint32_t          imm;
		int               pos;
		begin_test("full_and_order");
		ops = '{ADD, OR, SLL, SLT};
		for (int i = 0; i < 4; i++) begin
			a[i] = $random(seed);
			e[i] = alu_entry(ops[i], a[i], '0, 2'b01, '0, 4'd14, rob_index_t'(10 + i));
		end
		dispatch(e[0], e[1], 2'b11, 2'b00);
		@(negedge clk);
		check_value("alu_index_o[0]", 32'd2, uint32_t'(alu_index[0]));
		check_value("alu_index_o[1]", 32'd3, uint32_t'(alu_index[1]));
		dispatch(e[2], e[3], 2'b11, 2'b00);
		@(negedge clk);
		check_value("alu_ready_o when full", 32'd0, uint32_t'(alu_ready));
		// a taken branch broadcasts the awaited tag
		pc  = $random(seed) & 32'hffff_fffc;
		imm = 32'h0000_0040;
		dispatch(branch_entry(BEQ, pc, pc, pc, imm, 1'b1, 4'd14), '0, 2'b00, 2'b01);
		wait_tag(4'd14, pkt);
		check_value("release value", pc + imm, pkt.value);
		for (int i = 0; i < 4; i++) begin
			wait_tag(rob_index_t'(10 + i), pkt);
			check_value(ops[i].name(), alu_model(ops[i], a[i], pc + imm), pkt.value);
		end
		pos = 0;
		for (int i = log_start; i < cdb_log.size(); i++) begin
			if (cdb_log[i].reorder >= 10 && cdb_log[i].reorder <= 13) begin
				check_value("result order", uint32_t'(10 + pos), uint32_t'(cdb_log[i].reorder));
				pos++;
			end
		end
		end_test();
	endtask

	task automatic flush_stations();
		cdb_packet_t      pkt;
		reserve_station_t br;
		begin_test("flush");
		br                 = branch_entry(BNE, '0, 32'd5, 32'h100, 32'h20, 1'b0, 4'd7);
		br.operand_ready   = 2'b10;
		br.operand_addr[0] = 4'd15;
		// every waiting entry depends on tag 15
		dispatch(alu_entry(ADD, 32'd1, '0, 2'b01, '0, 4'd15, 4'd5),
		         alu_entry(SUB, 32'd2, '0, 2'b01, '0, 4'd15, 4'd6), 2'b11, 2'b00);
		dispatch(alu_entry(OR, 32'd3, '0, 2'b01, '0, 4'd15, 4'd8),
		         alu_entry(XOR, 32'd4, '0, 2'b01, '0, 4'd15, 4'd9), 2'b11, 2'b00);
		dispatch(br, '0, 2'b00, 2'b01);
		@(negedge clk);
		check_value("alu_ready_o full", 32'd0, uint32_t'(alu_ready));
		check_value("branch_ready_o held", 32'd1, uint32_t'(branch_ready));
		check_value("branch_index_o[0] held", 32'd1, uint32_t'(branch_index[0]));
		@(posedge clk);
		flush <= 1'b1;
		@(posedge clk);
		flush <= 1'b0;
		@(negedge clk);
		check_value("alu_ready_o", 32'd3, uint32_t'(alu_ready));
		check_value("branch_ready_o", 32'd3, uint32_t'(branch_ready));
		check_value("alu_index_o[0]", 32'd0, uint32_t'(alu_index[0]));
		check_value("alu_index_o[1]", 32'd1, uint32_t'(alu_index[1]));
		check_value("branch_index_o[0]", 32'd0, uint32_t'(branch_index[0]));
		check_value("branch_index_o[1]", 32'd1, uint32_t'(branch_index[1]));
		// flushed entries must not wake on tag 15
		dispatch(alu_entry(ADD, 32'd7, 32'd9, 2'b11, '0, '0, 4'd15), '0, 2'b01, 2'b00);
		wait_tag(4'd15, pkt);
		check_value("tag 15 value", 32'd16, pkt.value);
		repeat (TIMEOUT) @(posedge clk);
		check_value("tag 5 count", 32'd0, uint32_t'(count_tag(4'd5)));
		check_value("tag 6 count", 32'd0, uint32_t'(count_tag(4'd6)));
		check_value("tag 7 count", 32'd0, uint32_t'(count_tag(4'd7)));
		check_value("tag 8 count", 32'd0, uint32_t'(count_tag(4'd8)));
		check_value("tag 9 count", 32'd0, uint32_t'(count_tag(4'd9)));
		end_test();
	endtask

	initial begin
		int n;
		flush        = 1'b0;
		alu_taken    = '0;
		branch_taken = '0;
		rs           = '0;
		rob_valid    = '0;
		for (int i = 0; i < 16; i++) begin
			rob_mem[i] = '0;
		end
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		cur_test     = "reset";
		n            = 0;
		while (!rst_n && n < TIMEOUT) begin
			@(posedge clk);
			n++;
		end
		if (!rst_n)
			report_error("reset never released");
		@(posedge clk);
		run_alu_ops();
		fill_from_rob();
		wake_from_cdb();
		resolve_branches();
		fill_and_release();
		flush_stations();
		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// ==== verification/clk_gen.sv ====
`timescale 1ns/100ps

module clk_gen (
	output logic clk_o,
	output logic rst_n_o
);

	initial begin
		clk_o = 1'b0;
		forever #2 clk_o = ~clk_o;
	end

	// reset held low over five rising edges
	initial begin
		rst_n_o = 1'b0;
		repeat (5) @(posedge clk_o);
		rst_n_o <= 1'b1;
	end

endmodule

// ==== hdl/instr_exec.sv ====
`timescale 1ns/100ps
`include "exec_settings.svh"

module instr_exec (
	input  logic                             clk,
	input  logic                             rst_n_i,
	input  logic                             flush_i,
	output exec_pkg::rob_index_t       [3:0] rob_raddr_o,
	input  logic                       [3:0] rob_rdata_valid_i,
	input  exec_pkg::uint32_t          [3:0] rob_rdata_i,
	input  logic                       [1:0] alu_taken_i,
	output logic                       [1:0] alu_ready_o,
	output exec_pkg::rs_index_t        [1:0] alu_index_o,
	input  logic                       [1:0] branch_taken_i,
	output logic                       [1:0] branch_ready_o,
	output exec_pkg::rs_index_t        [1:0] branch_index_o,
	input  exec_pkg::reserve_station_t [1:0] rs_i,
	output exec_pkg::cdb_packet_t            cdb_o
);

	import exec_pkg::*;

	reserve_station_t [1:0] rs_cap;

	uint32_t    [`ALU_RS_SIZE-1:0] alu_data;
	logic       [`ALU_RS_SIZE-1:0] alu_data_ready;
	rob_index_t [`ALU_RS_SIZE-1:0] alu_data_reorder;
	logic       [`ALU_RS_SIZE-1:0] alu_data_ack;

	uint32_t          [`BRANCH_RS_SIZE-1:0] branch_data;
	logic             [`BRANCH_RS_SIZE-1:0] branch_data_ready;
	rob_index_t       [`BRANCH_RS_SIZE-1:0] branch_data_reorder;
	branch_resolved_t [`BRANCH_RS_SIZE-1:0] branch_resolved;
	logic             [`BRANCH_RS_SIZE-1:0] branch_data_ack;

	// rob read port and operand fill, two ports per slot
	for (genvar k = 0; k < 2; k++) begin : gen_capture
		assign rob_raddr_o[2*k]   = rs_i[k].operand_addr[0];
		assign rob_raddr_o[2*k+1] = rs_i[k].operand_addr[1];

		operand_capture operand_capture_i (
			.cdb_i             ( cdb_o                         ),
			.rob_rdata_valid_i ( rob_rdata_valid_i[2*k +: 2]   ),
			.rob_rdata_i       ( rob_rdata_i[2*k +: 2]         ),
			.rs_i              ( rs_i[k]                       ),
			.rs_o              ( rs_cap[k]                     )
		);
	end

	alu_rs alu_rs_i (
		.clk,
		.rst_n_i,
		.flush_i,
		.rs_taken_i     ( alu_taken_i      ),
		.rs_ready_o     ( alu_ready_o      ),
		.rs_index_o     ( alu_index_o      ),
		.rs_i           ( rs_cap           ),
		.cdb_i          ( cdb_o            ),
		.data_o         ( alu_data         ),
		.data_ready_o   ( alu_data_ready   ),
		.data_reorder_o ( alu_data_reorder ),
		.data_ack_i     ( alu_data_ack     )
	);

	branch_rs branch_rs_i (
		.clk,
		.rst_n_i,
		.flush_i,
		.rs_taken_i     ( branch_taken_i      ),
		.rs_ready_o     ( branch_ready_o      ),
		.rs_index_o     ( branch_index_o      ),
		.rs_i           ( rs_cap              ),
		.cdb_i          ( cdb_o               ),
		.data_o         ( branch_data         ),
		.data_ready_o   ( branch_data_ready   ),
		.data_reorder_o ( branch_data_reorder ),
		.resolved_o     ( branch_resolved     ),
		.data_ack_i     ( branch_data_ack     )
	);

	cdb_arbiter cdb_arbiter_i (
		.clk,
		.rst_n_i,
		.flush_i,
		.alu_data_i            ( alu_data            ),
		.alu_data_ready_i      ( alu_data_ready      ),
		.alu_data_reorder_i    ( alu_data_reorder    ),
		.alu_data_ack_o        ( alu_data_ack        ),
		.branch_data_i         ( branch_data         ),
		.branch_data_ready_i   ( branch_data_ready   ),
		.branch_data_reorder_i ( branch_data_reorder ),
		.branch_resolved_i     ( branch_resolved     ),
		.branch_data_ack_o     ( branch_data_ack     ),
		.cdb_o
	);

endmodule

// ==== hdl/cdb_arbiter.sv ====
`timescale 1ns/100ps
`include "exec_settings.svh"

module cdb_arbiter (
	input  logic                                             clk,
	input  logic                                             rst_n_i,
	input  logic                                             flush_i,
	input  exec_pkg::uint32_t          [`ALU_RS_SIZE-1:0]    alu_data_i,
	input  logic                       [`ALU_RS_SIZE-1:0]    alu_data_ready_i,
	input  exec_pkg::rob_index_t       [`ALU_RS_SIZE-1:0]    alu_data_reorder_i,
	output logic                       [`ALU_RS_SIZE-1:0]    alu_data_ack_o,
	input  exec_pkg::uint32_t          [`BRANCH_RS_SIZE-1:0] branch_data_i,
	input  logic                       [`BRANCH_RS_SIZE-1:0] branch_data_ready_i,
	input  exec_pkg::rob_index_t       [`BRANCH_RS_SIZE-1:0] branch_data_reorder_i,
	input  exec_pkg::branch_resolved_t [`BRANCH_RS_SIZE-1:0] branch_resolved_i,
	output logic                       [`BRANCH_RS_SIZE-1:0] branch_data_ack_o,
	output exec_pkg::cdb_packet_t                            cdb_o
);

	import exec_pkg::*;

	cdb_packet_t pick;

	// branches first, then alu, lowest index first
	always_comb begin
		pick              = '0;
		alu_data_ack_o    = '0;
		branch_data_ack_o = '0;
		for (int i = 0; i < `BRANCH_RS_SIZE; i++) begin
			if (!pick.valid && branch_data_ready_i[i]) begin
				branch_data_ack_o[i] = 1'b1;
				pick.valid           = 1'b1;
				pick.reorder         = branch_data_reorder_i[i];
				pick.value           = branch_data_i[i];
				pick.is_branch       = 1'b1;
				pick.taken           = branch_resolved_i[i].taken;
				pick.mispredict      = branch_resolved_i[i].mispredict;
			end
		end
		for (int i = 0; i < `ALU_RS_SIZE; i++) begin
			if (!pick.valid && alu_data_ready_i[i]) begin
				alu_data_ack_o[i] = 1'b1;
				pick.valid        = 1'b1;
				pick.reorder      = alu_data_reorder_i[i];
				pick.value        = alu_data_i[i];
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i)
			cdb_o <= '0;
		else if (flush_i)
			cdb_o <= '0;
		else
			cdb_o <= pick;
	end

endmodule

// ==== branch_rs/branch_rs.sv ====
`timescale 1ns/100ps
`include "exec_settings.svh"

module branch_rs (
	input  logic                                                clk,
	input  logic                                                rst_n_i,
	input  logic                                                flush_i,
	input  logic                                          [1:0] rs_taken_i,
	output logic                                          [1:0] rs_ready_o,
	output exec_pkg::rs_index_t                           [1:0] rs_index_o,
	input  exec_pkg::reserve_station_t                    [1:0] rs_i,
	input  exec_pkg::cdb_packet_t                               cdb_i,
	output exec_pkg::uint32_t          [`BRANCH_RS_SIZE-1:0]    data_o,
	output logic                       [`BRANCH_RS_SIZE-1:0]    data_ready_o,
	output exec_pkg::rob_index_t       [`BRANCH_RS_SIZE-1:0]    data_reorder_o,
	output exec_pkg::branch_resolved_t [`BRANCH_RS_SIZE-1:0]    resolved_o,
	input  logic                       [`BRANCH_RS_SIZE-1:0]    data_ack_i
);

	import exec_pkg::*;

	localparam int N  = `BRANCH_RS_SIZE;
	localparam int IW = $clog2(N);

	logic             [N-1:0]  slot_valid;
	reserve_station_t [N-1:0]  slot;
	reserve_station_t [N-1:0]  woken;
	logic             [1:0]    wr_en;
	logic                      sel_hit;
	logic             [IW-1:0] sel_idx;
	reserve_station_t          cur;
	logic                      take;
	uint32_t                   next_pc;

	always_comb begin
		rs_ready_o = '0;
		rs_index_o = '0;
		for (int i = 0; i < N; i++) begin
			if (!slot_valid[i]) begin
				if (!rs_ready_o[0]) begin
					rs_ready_o[0] = 1'b1;
					rs_index_o[0] = rs_index_t'(i);
				end else if (!rs_ready_o[1]) begin
					rs_ready_o[1] = 1'b1;
					rs_index_o[1] = rs_index_t'(i);
				end
			end
		end
		for (int k = 0; k < 2; k++) begin
			wr_en[k] = rs_taken_i[k] && rs_ready_o[k] && rs_i[k].valid && rs_i[k].unit_branch;
		end
	end

	always_comb begin
		woken   = slot;
		sel_hit = 1'b0;
		sel_idx = '0;
		for (int i = 0; i < N; i++) begin
			for (int j = 0; j < 2; j++) begin
				if (!woken[i].operand_ready[j] && cdb_i.valid &&
				    cdb_i.reorder == woken[i].operand_addr[j]) begin
					woken[i].operand[j]       = cdb_i.value;
					woken[i].operand_ready[j] = 1'b1;
				end
			end
		end
		for (int i = 0; i < N; i++) begin
			if (!sel_hit && slot_valid[i] && (&woken[i].operand_ready) && !data_ready_o[i]) begin
				sel_hit = 1'b1;
				sel_idx = IW'(i);
			end
		end
	end

	assign cur = woken[sel_idx];

	// blt and bge compare signed
	always_comb begin
		case (cur.op.branch)
			BEQ:     take = cur.operand[0] == cur.operand[1];
			BNE:     take = cur.operand[0] != cur.operand[1];
			BLT:     take = $signed(cur.operand[0]) < $signed(cur.operand[1]);
			BGE:     take = $signed(cur.operand[0]) >= $signed(cur.operand[1]);
			default: take = 1'b0;
		endcase
		next_pc = take ? cur.pc + cur.imm : cur.pc + uint32_t'(4);
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			slot_valid   <= '0;
			data_ready_o <= '0;
		end else if (flush_i) begin
			slot_valid   <= '0;
			data_ready_o <= '0;
		end else begin
			for (int i = 0; i < N; i++) begin
				if (data_ack_i[i]) begin
					slot_valid[i]   <= 1'b0;
					data_ready_o[i] <= 1'b0;
				end
			end
			if (sel_hit)
				data_ready_o[sel_idx] <= 1'b1;
			for (int k = 0; k < 2; k++) begin
				if (wr_en[k])
					slot_valid[rs_index_o[k][IW-1:0]] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		slot <= woken;
		for (int k = 0; k < 2; k++) begin
			if (wr_en[k])
				slot[rs_index_o[k][IW-1:0]] <= rs_i[k];
		end
		if (sel_hit) begin
			data_o[sel_idx]                <= next_pc;
			resolved_o[sel_idx].taken      <= take;
			resolved_o[sel_idx].mispredict <= take != cur.pred_taken;
		end
	end

	always_comb begin
		for (int i = 0; i < N; i++) begin
			data_reorder_o[i] = slot[i].reorder;
		end
	end

endmodule

// ==== alu_rs/alu_rs.sv ====
`timescale 1ns/100ps
`include "exec_settings.svh"

module alu_rs (
	input  logic                                              clk,
	input  logic                                              rst_n_i,
	input  logic                                              flush_i,
	input  logic                                        [1:0] rs_taken_i,
	output logic                                        [1:0] rs_ready_o,
	output exec_pkg::rs_index_t                         [1:0] rs_index_o,
	input  exec_pkg::reserve_station_t                  [1:0] rs_i,
	input  exec_pkg::cdb_packet_t                             cdb_i,
	output exec_pkg::uint32_t          [`ALU_RS_SIZE-1:0]     data_o,
	output logic                       [`ALU_RS_SIZE-1:0]     data_ready_o,
	output exec_pkg::rob_index_t       [`ALU_RS_SIZE-1:0]     data_reorder_o,
	input  logic                       [`ALU_RS_SIZE-1:0]     data_ack_i
);

	import exec_pkg::*;

	localparam int N  = `ALU_RS_SIZE;
	localparam int IW = $clog2(N);
	localparam int SW = $clog2(`DATA_WIDTH);

	logic             [N-1:0] slot_valid;
	reserve_station_t [N-1:0] slot;
	reserve_station_t [N-1:0] woken;
	logic             [1:0]   wr_en;
	logic                     sel_hit;
	logic             [IW-1:0] sel_idx;
	uint32_t                  op_a;
	uint32_t                  op_b;
	uint32_t                  result;

	// slot 0 takes the lowest free entry, slot 1 the next one
	always_comb begin
		rs_ready_o = '0;
		rs_index_o = '0;
		for (int i = 0; i < N; i++) begin
			if (!slot_valid[i]) begin
				if (!rs_ready_o[0]) begin
					rs_ready_o[0] = 1'b1;
					rs_index_o[0] = rs_index_t'(i);
				end else if (!rs_ready_o[1]) begin
					rs_ready_o[1] = 1'b1;
					rs_index_o[1] = rs_index_t'(i);
				end
			end
		end
		for (int k = 0; k < 2; k++) begin
			wr_en[k] = rs_taken_i[k] && rs_ready_o[k] && rs_i[k].valid && !rs_i[k].unit_branch;
		end
	end

	// cdb wakeup, then oldest ready entry without a result
	always_comb begin
		woken   = slot;
		sel_hit = 1'b0;
		sel_idx = '0;
		for (int i = 0; i < N; i++) begin
			for (int j = 0; j < 2; j++) begin
				if (!woken[i].operand_ready[j] && cdb_i.valid &&
				    cdb_i.reorder == woken[i].operand_addr[j]) begin
					woken[i].operand[j]       = cdb_i.value;
					woken[i].operand_ready[j] = 1'b1;
				end
			end
		end
		for (int i = 0; i < N; i++) begin
			if (!sel_hit && slot_valid[i] && (&woken[i].operand_ready) && !data_ready_o[i]) begin
				sel_hit = 1'b1;
				sel_idx = IW'(i);
			end
		end
	end

	assign op_a = woken[sel_idx].operand[0];
	assign op_b = woken[sel_idx].operand[1];

	always_comb begin
		case (woken[sel_idx].op.alu)
			ADD:     result = op_a + op_b;
			SUB:     result = op_a - op_b;
			AND:     result = op_a & op_b;
			OR:      result = op_a | op_b;
			XOR:     result = op_a ^ op_b;
			SLL:     result = op_a << op_b[SW-1:0];
			SRL:     result = op_a >> op_b[SW-1:0];
			SLT:     result = uint32_t'($signed(op_a) < $signed(op_b));
			default: result = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			slot_valid   <= '0;
			data_ready_o <= '0;
		end else if (flush_i) begin
			slot_valid   <= '0;
			data_ready_o <= '0;
		end else begin
			for (int i = 0; i < N; i++) begin
				if (data_ack_i[i]) begin
					slot_valid[i]   <= 1'b0;
					data_ready_o[i] <= 1'b0;
				end
			end
			if (sel_hit)
				data_ready_o[sel_idx] <= 1'b1;
			for (int k = 0; k < 2; k++) begin
				if (wr_en[k])
					slot_valid[rs_index_o[k][IW-1:0]] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		slot <= woken;
		for (int k = 0; k < 2; k++) begin
			if (wr_en[k])
				slot[rs_index_o[k][IW-1:0]] <= rs_i[k];
		end
		if (sel_hit)
			data_o[sel_idx] <= result;
	end

	always_comb begin
		for (int i = 0; i < N; i++) begin
			data_reorder_o[i] = slot[i].reorder;
		end
	end

endmodule

// ==== hdl/operand_capture.sv ====
`timescale 1ns/100ps

module operand_capture (
	input  exec_pkg::cdb_packet_t            cdb_i,
	input  logic                       [1:0] rob_rdata_valid_i,
	input  exec_pkg::uint32_t          [1:0] rob_rdata_i,
	input  exec_pkg::reserve_station_t       rs_i,
	output exec_pkg::reserve_station_t       rs_o
);

	logic [1:0] cdb_hit;

	// tag match against the broadcast of this cycle
	always_comb begin
		for (int j = 0; j < 2; j++) begin
			cdb_hit[j] = cdb_i.valid && (cdb_i.reorder == rs_i.operand_addr[j]);
		end
	end

	always_comb begin
		rs_o = rs_i;
		for (int j = 0; j < 2; j++) begin
			if (!rs_i.operand_ready[j]) begin
				// rob word wins over the cdb
				if (rob_rdata_valid_i[j]) begin
					rs_o.operand[j]       = rob_rdata_i[j];
					rs_o.operand_ready[j] = 1'b1;
				end else if (cdb_hit[j]) begin
					rs_o.operand[j]       = cdb_i.value;
					rs_o.operand_ready[j] = 1'b1;
				end
			end
		end
	end

endmodule

// ==== common/exec_pkg.sv ====
`include "exec_settings.svh"

package exec_pkg;

	typedef logic [`DATA_WIDTH-1:0] uint32_t;
	typedef logic [$clog2(`ROB_SIZE)-1:0] rob_index_t;
	typedef logic [$clog2(`ALU_RS_SIZE)-1:0] rs_index_t;

	typedef enum logic [3:0] {
		ADD, SUB, AND, OR, XOR, SLL, SRL, SLT
	} alu_op_e;

	typedef enum logic [3:0] {
		BEQ, BNE, BLT, BGE
	} branch_cond_e;

	// one function field, read per station
	typedef union packed {
		alu_op_e      alu;
		branch_cond_e branch;
	} exec_op_u;

	typedef struct packed {
		logic                   valid;
		logic                   unit_branch;
		exec_op_u               op;
		uint32_t    [1:0]       operand;
		logic       [1:0]       operand_ready;
		rob_index_t [1:0]       operand_addr;
		rob_index_t             reorder;
		uint32_t                pc;
		uint32_t                imm;
		logic                   pred_taken;
	} reserve_station_t;

	typedef struct packed {
		logic       valid;
		rob_index_t reorder;
		uint32_t    value;
		logic       is_branch;
		logic       taken;
		logic       mispredict;
	} cdb_packet_t;

	typedef struct packed {
		logic taken;
		logic mispredict;
	} branch_resolved_t;

endpackage

// ==== common/exec_settings.svh ====
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

// station depths
`define ALU_RS_SIZE 4
`define BRANCH_RS_SIZE 2

// reorder buffer depth, sets the tag width
`define ROB_SIZE 16

// datapath width
`define DATA_WIDTH 32

`endif
